// ==== rtl/shade_pkg.sv ====
`default_nettype none

package shade_pkg;

    //////////////////////////////
    // fixed-point formats
    //////////////////////////////

    localparam int FRAC_POS   = 16;
    localparam int FRAC_COLOR = 14;

    // Q16.16 coordinates and distances
    typedef logic signed [31:0] pos_t;
    // Q2.14 unit direction component
    typedef logic signed [15:0] dir_t;
    // Q2.14 colour or intensity, never negative
    typedef logic [15:0] color_t;

    localparam color_t COLOR_ONE = 16'd16384;

    // face normal axis
    typedef enum logic [1:0] {
        AXIS_X,
        AXIS_Y,
        AXIS_Z
    } axis_e;

    // block material, unlisted codes render black
    typedef enum logic [2:0] {
        MAT_BLUE  = 3'd0,
        MAT_RED   = 3'd1,
        MAT_WHITE = 3'd2
    } material_e;

    //////////////////////////////
    // scene constants
    //////////////////////////////

    // eye at (1800, 1800, -300)
    localparam pos_t EYE_X = 32'sh0708_0000;
    localparam pos_t EYE_Y = 32'sh0708_0000;
    localparam pos_t EYE_Z = -32'sh012C_0000;

    localparam int MAX_LIGHTS = 3;

    // unit directions per light, x y z, 0.6 and 0.8 rounded down
    localparam dir_t LIGHT_DIR [MAX_LIGHTS][3] = '{
        '{16'sd0, 16'sd9830, -16'sd13107},
        '{16'sd9830, 16'sd0, -16'sd13107},
        '{-16'sd9830, 16'sd13107, 16'sd0}
    };

    // intensity per light, r g b
    localparam color_t LIGHT_INTENSITY [MAX_LIGHTS][3] = '{
        '{16'd4096, 16'd8192, 16'd4096},
        '{16'd12288, 16'd8192, 16'd12288},
        '{16'd4096, 16'd8192, 16'd4096}
    };

endpackage

`default_nettype wire

// ==== rtl/shade_ifs.sv ====
`timescale 1ns/1ps
`default_nettype none

// face description of one hit, one driver fanning out to every light
interface surface_if;
    import shade_pkg::*;

    logic      valid;
    axis_e     normal_axis;
    logic      normal_neg;
    material_e material;

    modport src (
        output valid,
        output normal_axis,
        output normal_neg,
        output material
    );

    modport dst (
        input valid,
        input normal_axis,
        input normal_neg,
        input material
    );
endinterface

// masked diffuse term of a single light
interface light_term_if;
    import shade_pkg::*;

    logic   valid;
    color_t red;
    color_t green;
    color_t blue;

    modport src (
        output valid,
        output red,
        output green,
        output blue
    );

    modport dst (
        input valid,
        input red,
        input green,
        input blue
    );
endinterface

`default_nettype wire

// ==== rtl/hit_point_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module hit_point_unit (
    input  logic                 clk_in,
    input  logic                 rst_in,
    input  logic                 valid_in,
    input  shade_pkg::pos_t      ray_x,
    input  shade_pkg::pos_t      ray_y,
    input  shade_pkg::pos_t      ray_z,
    input  shade_pkg::pos_t      t_in,
    input  shade_pkg::pos_t      block_x,
    input  shade_pkg::pos_t      block_y,
    input  shade_pkg::pos_t      block_z,
    input  shade_pkg::material_e block_color,
    surface_if.src               surf
);
    import shade_pkg::*;

    // stage 1, scaled ray plus matching delays
    pos_t      scaled_x, scaled_y, scaled_z;
    pos_t      blk_x_d1, blk_y_d1, blk_z_d1;
    material_e mat_d1;
    logic      valid_d1;

    // stage 2, hit point relative to the block
    pos_t      rel_x, rel_y, rel_z;
    material_e mat_d2;
    logic      valid_d2;

    logic [32:0] mag_x, mag_y, mag_z;

    // Q16.16 product, middle 32 bits of the full result
    function automatic pos_t mul_q16(input pos_t a, input pos_t b);
        logic signed [63:0] full;
        full = a * b;
        return full[FRAC_POS +: 32];
    endfunction

    // widened so that the most negative value still has a magnitude
    function automatic logic [32:0] abs_mag(input pos_t v);
        logic signed [32:0] wide;
        wide = v;
        return wide[32] ? 33'(-wide) : 33'(wide);
    endfunction

    //////////////////////////////
    // valid pipeline
    //////////////////////////////

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            valid_d1   <= 1'b0;
            valid_d2   <= 1'b0;
            surf.valid <= 1'b0;
        end else begin
            valid_d1   <= valid_in;
            valid_d2   <= valid_d1;
            surf.valid <= valid_d2;
        end
    end

    //////////////////////////////
    // datapath
    //////////////////////////////

    always_ff @(posedge clk_in) begin
        scaled_x <= mul_q16(ray_x, t_in);
        scaled_y <= mul_q16(ray_y, t_in);
        scaled_z <= mul_q16(ray_z, t_in);
        blk_x_d1 <= block_x;
        blk_y_d1 <= block_y;
        blk_z_d1 <= block_z;
        mat_d1   <= block_color;

        // eye + t * ray - block
        rel_x  <= scaled_x + EYE_X - blk_x_d1;
        rel_y  <= scaled_y + EYE_Y - blk_y_d1;
        rel_z  <= scaled_z + EYE_Z - blk_z_d1;
        mat_d2 <= mat_d1;
    end

    assign mag_x = abs_mag(rel_x);
    assign mag_y = abs_mag(rel_y);
    assign mag_z = abs_mag(rel_z);

    // dominant axis, ties go to x then y
    always_ff @(posedge clk_in) begin
        surf.material <= mat_d2;
        if (mag_x >= mag_y && mag_x >= mag_z) begin
            surf.normal_axis <= AXIS_X;
            surf.normal_neg  <= rel_x[31];
        end else if (mag_y >= mag_z) begin
            surf.normal_axis <= AXIS_Y;
            surf.normal_neg  <= rel_y[31];
        end else begin
            surf.normal_axis <= AXIS_Z;
            surf.normal_neg  <= rel_z[31];
        end
    end

endmodule

`default_nettype wire

// ==== rtl/light_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module light_unit #(
    parameter int LIGHT_INDEX = 0
) (
    input  logic     clk_in,
    input  logic     rst_in,
    surface_if.dst   surf,
    light_term_if.src term
);
    import shade_pkg::*;

    // stage 1
    dir_t      dir_sel;
    dir_t      dir_signed;
    color_t    lambert_next;
    color_t    lambert;
    material_e mat_d1;
    logic      valid_d1;

    // stage 2
    logic [31:0] prod [3];
    color_t      scaled [3];
    material_e   mat_d2;
    logic        valid_d2;

    logic [2:0] mask;

    // channel enables, bit 0 red, bit 1 green, bit 2 blue
    function automatic logic [2:0] channel_mask(input material_e mat);
        case (mat)
            MAT_BLUE:  return 3'b100;
            MAT_RED:   return 3'b001;
            MAT_WHITE: return 3'b111;
            default:   return 3'b000;
        endcase
    endfunction

    //////////////////////////////
    // lambert term
    //////////////////////////////

    // dot product with an axis normal is one direction component
    always_comb begin
        dir_sel      = LIGHT_DIR[LIGHT_INDEX][surf.normal_axis];
        dir_signed   = surf.normal_neg ? -dir_sel : dir_sel;
        // faces turned away from the light get nothing
        lambert_next = dir_signed[15] ? '0 : color_t'(dir_signed);
    end

    always_comb begin
        for (int c = 0; c < 3; c++) begin
            prod[c] = lambert * LIGHT_INTENSITY[LIGHT_INDEX][c];
        end
    end

    assign mask = channel_mask(mat_d2);

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            valid_d1   <= 1'b0;
            valid_d2   <= 1'b0;
            term.valid <= 1'b0;
        end else begin
            valid_d1   <= surf.valid;
            valid_d2   <= valid_d1;
            term.valid <= valid_d2;
        end
    end

    always_ff @(posedge clk_in) begin
        lambert <= lambert_next;
        mat_d1  <= surf.material;
        // back to Q2.14, truncating
        for (int c = 0; c < 3; c++) begin
            scaled[c] <= prod[c][FRAC_COLOR +: 16];
        end
        mat_d2     <= mat_d1;
        term.red   <= mask[0] ? scaled[0] : '0;
        term.green <= mask[1] ? scaled[1] : '0;
        term.blue  <= mask[2] ? scaled[2] : '0;
    end

endmodule

`default_nettype wire

// ==== rtl/color_accumulator.sv ====
`timescale 1ns/1ps
`default_nettype none

module color_accumulator #(
    parameter int NUM_LIGHTS = 3
) (
    input  logic              clk_in,
    input  logic              rst_in,
    light_term_if.dst         terms [NUM_LIGHTS],
    output shade_pkg::color_t r_out,
    output shade_pkg::color_t g_out,
    output shade_pkg::color_t b_out,
    output logic              rgb_valid
);
    import shade_pkg::*;

    // room for every light at full scale
    localparam int SUM_W = 16 + $clog2(MAX_LIGHTS + 1);

    color_t red_t   [NUM_LIGHTS];
    color_t green_t [NUM_LIGHTS];
    color_t blue_t  [NUM_LIGHTS];

    logic [SUM_W-1:0] sum_r_next, sum_g_next, sum_b_next;
    logic [SUM_W-1:0] sum_r, sum_g, sum_b;
    logic             sum_valid;

    generate
        for (genvar i = 0; i < NUM_LIGHTS; i++) begin : g_unpack
            assign red_t[i]   = terms[i].red;
            assign green_t[i] = terms[i].green;
            assign blue_t[i]  = terms[i].blue;
        end
    endgenerate

    always_comb begin
        sum_r_next = '0;
        sum_g_next = '0;
        sum_b_next = '0;
        for (int i = 0; i < NUM_LIGHTS; i++) begin
            sum_r_next = sum_r_next + SUM_W'(red_t[i]);
            sum_g_next = sum_g_next + SUM_W'(green_t[i]);
            sum_b_next = sum_b_next + SUM_W'(blue_t[i]);
        end
    end

    always_ff @(posedge clk_in) begin
        sum_r <= sum_r_next;
        sum_g <= sum_g_next;
        sum_b <= sum_b_next;
    end

    // lights run in lock step, light 0 speaks for all
    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            sum_valid <= 1'b0;
            rgb_valid <= 1'b0;
            r_out     <= '0;
            g_out     <= '0;
            b_out     <= '0;
        end else begin
            sum_valid <= terms[0].valid;
            rgb_valid <= sum_valid;
            r_out     <= (sum_r > SUM_W'(COLOR_ONE)) ? COLOR_ONE : sum_r[15:0];
            g_out     <= (sum_g > SUM_W'(COLOR_ONE)) ? COLOR_ONE : sum_g[15:0];
            b_out     <= (sum_b > SUM_W'(COLOR_ONE)) ? COLOR_ONE : sum_b[15:0];
        end
    end

endmodule

`default_nettype wire

// ==== rtl/pixel_shader_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module pixel_shader_top #(
    parameter int NUM_LIGHTS = 3
) (
    input  logic                 clk_in,
    input  logic                 rst_in,
    input  logic                 valid_in,
    input  shade_pkg::pos_t      ray_x,
    input  shade_pkg::pos_t      ray_y,
    input  shade_pkg::pos_t      ray_z,
    input  shade_pkg::pos_t      t_in,
    input  shade_pkg::pos_t      block_x,
    input  shade_pkg::pos_t      block_y,
    input  shade_pkg::pos_t      block_z,
    input  shade_pkg::material_e block_color,
    output shade_pkg::color_t    r_out,
    output shade_pkg::color_t    g_out,
    output shade_pkg::color_t    b_out,
    output logic                 rgb_valid
);

    //////////////////////////////
    // internal links
    //////////////////////////////

    surface_if    surf ();
    light_term_if terms [NUM_LIGHTS] ();

    // hit point and face, 3 cycles
    hit_point_unit u_hit (
        .clk_in      (clk_in),
        .rst_in      (rst_in),
        .valid_in    (valid_in),
        .ray_x       (ray_x),
        .ray_y       (ray_y),
        .ray_z       (ray_z),
        .t_in        (t_in),
        .block_x     (block_x),
        .block_y     (block_y),
        .block_z     (block_z),
        .block_color (block_color),
        .surf        (surf)
    );

    //////////////////////////////
    // one diffuse unit per light
    //////////////////////////////

    // 3 cycles each, all in parallel
    generate
        for (genvar i = 0; i < NUM_LIGHTS; i++) begin : g_light
            light_unit #(
                .LIGHT_INDEX (i)
            ) u_light (
                .clk_in (clk_in),
                .rst_in (rst_in),
                .surf   (surf),
                .term   (terms[i])
            );
        end
    endgenerate

    // sum and clamp, 2 cycles
    color_accumulator #(
        .NUM_LIGHTS (NUM_LIGHTS)
    ) u_acc (
        .clk_in    (clk_in),
        .rst_in    (rst_in),
        .terms     (terms),
        .r_out     (r_out),
        .g_out     (g_out),
        .b_out     (b_out),
        .rgb_valid (rgb_valid)
    );

endmodule

`default_nettype wire

// ==== testbench/pixel_shader_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module pixel_shader_tb;
    import shade_pkg::*;

    localparam int CLK_PERIOD    = 8;
    localparam int PIPE_DEPTH    = 8;
    localparam int RESET_CYCLES  = 2;
    localparam int FLUSH_CYCLES  = 12;
    localparam int FACE_PIXELS   = 7;
    localparam int MASK_PIXELS   = 4;
    localparam int BRIGHT_PIXELS = 1;
    localparam int STREAM_PIXELS = 40;
    localparam int GAP_PIXELS    = 20;
    localparam int MAX_GAP       = 3;
    localparam int BUDGET_CYCLES = RESET_CYCLES + FLUSH_CYCLES + FACE_PIXELS + MASK_PIXELS
                                 + BRIGHT_PIXELS + STREAM_PIXELS + GAP_PIXELS * (1 + MAX_GAP)
                                 + 5 * PIPE_DEPTH;
    localparam int WATCHDOG_NS   = 2 * BUDGET_CYCLES * CLK_PERIOD;

    // eye position in Q16.16
    localparam int EYE_POS [3] = '{1800 * 65536, 1800 * 65536, -300 * 65536};
    // light directions in Q2.14 with 0.6 and 0.8 rounded down
    localparam int DIR_TAB [3][3] = '{
        '{0, 9830, -13107},
        '{9830, 0, -13107},
        '{-9830, 13107, 0}
    };
    // r g b intensity per light
    localparam int INTEN_TAB [3][3] = '{
        '{4096, 8192, 4096},
        '{12288, 8192, 12288},
        '{4096, 8192, 4096}
    };

    logic      clk_in;
    logic      rst_in;
    logic      valid_in;
    pos_t      ray_x, ray_y, ray_z, t_in;
    pos_t      block_x, block_y, block_z;
    material_e block_color;
    color_t    r_out, g_out, b_out;
    logic      rgb_valid;

    // expected results in flight with slot 7 due at this falling edge
    logic        exp_v [PIPE_DEPTH];
    int          exp_r [PIPE_DEPTH];
    int          exp_g [PIPE_DEPTH];
    int          exp_b [PIPE_DEPTH];
    int unsigned seed_word;
    int          pixels_checked;

    pixel_shader_top uut (
        .clk_in      (clk_in),
        .rst_in      (rst_in),
        .valid_in    (valid_in),
        .ray_x       (ray_x),
        .ray_y       (ray_y),
        .ray_z       (ray_z),
        .t_in        (t_in),
        .block_x     (block_x),
        .block_y     (block_y),
        .block_z     (block_z),
        .block_color (block_color),
        .r_out       (r_out),
        .g_out       (g_out),
        .b_out       (b_out),
        .rgb_valid   (rgb_valid)
    );

    initial begin
        clk_in = 1'b0;
        forever #(CLK_PERIOD / 2) clk_in = ~clk_in;
    end

    //////////////////////////////
    // reference model
    //////////////////////////////

    function automatic void shade_model(
        input  pos_t       rx, ry, rz, t, bx, by, bz,
        input  logic [2:0] mat,
        output int         r_exp, g_exp, b_exp
    );
        pos_t               ray [3];
        pos_t               blk [3];
        pos_t               rel [3];
        longint             mag [3];
        logic signed [63:0] full;
        int                 axis;
        bit                 neg;
        int                 lam;
        int                 sum [3];
        bit                 en [3];
        ray = '{rx, ry, rz};
        blk = '{bx, by, bz};
        for (int k = 0; k < 3; k++) begin
            full   = longint'(ray[k]) * longint'(t);
            rel[k] = full[47:16] + EYE_POS[k] - blk[k];
            mag[k] = (rel[k] < 0) ? -longint'(rel[k]) : longint'(rel[k]);
        end
        // largest magnitude wins and ties go to x then y
        if (mag[0] >= mag[1] && mag[0] >= mag[2]) begin
            axis = 0;
        end else if (mag[1] >= mag[2]) begin
            axis = 1;
        end else begin
            axis = 2;
        end
        neg   = rel[axis] < 0;
        en[0] = (mat == 3'd1) || (mat == 3'd2);
        en[1] = (mat == 3'd2);
        en[2] = (mat == 3'd0) || (mat == 3'd2);
        sum   = '{0, 0, 0};
        for (int l = 0; l < 3; l++) begin
            lam = neg ? -DIR_TAB[l][axis] : DIR_TAB[l][axis];
            if (lam < 0) begin
                lam = 0;
            end
            for (int c = 0; c < 3; c++) begin
                if (en[c]) begin
                    sum[c] += (lam * INTEN_TAB[l][c]) >>> 14;
                end
            end
        end
        r_exp = (sum[0] > 16384) ? 16384 : sum[0];
        g_exp = (sum[1] > 16384) ? 16384 : sum[1];
        b_exp = (sum[2] > 16384) ? 16384 : sum[2];
    endfunction

    //////////////////////////////
    // drive and compare
    //////////////////////////////

    task automatic check_value(input string name, input logic [15:0] expected,
                               input logic [15:0] actual);
        assert (actual === expected) else begin
            $display("error at %0t ns: %s expected %0d, actual %0d",
                     $time, name, expected, actual);
            $display("ERRORS FOUND");
            $fatal(1, "output mismatch");
        end
    endtask

    // compares the slot that is due and then drives the next input
    task automatic drive_cycle(input logic v, input pos_t rx, ry, rz, t, bx, by, bz,
                               input logic [2:0] mat);
        int er, eg, eb;
        check_value("rgb_valid", 16'(exp_v[PIPE_DEPTH-1]), 16'(rgb_valid));
        if (exp_v[PIPE_DEPTH-1]) begin
            check_value("r_out", 16'(exp_r[PIPE_DEPTH-1]), r_out);
            check_value("g_out", 16'(exp_g[PIPE_DEPTH-1]), g_out);
            check_value("b_out", 16'(exp_b[PIPE_DEPTH-1]), b_out);
            pixels_checked++;
        end
        for (int i = PIPE_DEPTH - 1; i > 0; i--) begin
            exp_v[i] = exp_v[i-1];
            exp_r[i] = exp_r[i-1];
            exp_g[i] = exp_g[i-1];
            exp_b[i] = exp_b[i-1];
        end
        shade_model(rx, ry, rz, t, bx, by, bz, mat, er, eg, eb);
        exp_v[0] = v;
        exp_r[0] = er;
        exp_g[0] = eg;
        exp_b[0] = eb;
        valid_in    = v;
        ray_x       = rx;
        ray_y       = ry;
        ray_z       = rz;
        t_in        = t;
        block_x     = bx;
        block_y     = by;
        block_z     = bz;
        block_color = material_e'(mat);
        @(negedge clk_in);
    endtask

    // idle inputs use an unused material so the datapath settles to black
    task automatic idle_cycles(input int n);
        repeat (n) begin
            drive_cycle(1'b0, 0, 0, 0, 0, 0, 0, 0, 3'd7);
        end
    endtask

    // ray (0.5, -0.25, 1.0) at t = 300 lands on (1950, 1725, 0)
    task automatic send_relative(input pos_t rel_x, rel_y, rel_z, input logic [2:0] mat);
        pos_t bx, by, bz;
        bx = (32'sd1950 <<< 16) - rel_x;
        by = (32'sd1725 <<< 16) - rel_y;
        bz = 32'sd0 - rel_z;
        drive_cycle(1'b1, 32'sd32768, -32'sd16384, 32'sd65536, 32'sd300 <<< 16,
                    bx, by, bz, mat);
    endtask

    task automatic send_random_pixel();
        pos_t       rx, ry, rz, t, bx, by, bz;
        logic [2:0] mat;
        // ray components in [-1, 1) with t below 2048 and integer block positions
        rx  = $urandom_range(131071);
        rx  = rx - 65536;
        ry  = $urandom_range(131071);
        ry  = ry - 65536;
        rz  = $urandom_range(131071);
        rz  = rz - 65536;
        t   = $urandom_range(32'h07FF_FFFF);
        bx  = $urandom_range(4095) << 16;
        by  = $urandom_range(4095) << 16;
        bz  = $urandom_range(4095) << 16;
        mat = $urandom_range(7);
        drive_cycle(1'b1, rx, ry, rz, t, bx, by, bz, mat);
    endtask

    //////////////////////////////
    // tests
    //////////////////////////////

    task automatic verify_reset();
        // first rising edge applies the reset
        @(posedge clk_in);
        repeat (RESET_CYCLES) begin
            @(negedge clk_in);
            check_value("rgb_valid", 16'd0, 16'(rgb_valid));
            check_value("r_out", 16'd0, r_out);
            check_value("g_out", 16'd0, g_out);
            check_value("b_out", 16'd0, b_out);
        end
        rst_in = 1'b0;
        idle_cycles(PIPE_DEPTH);
        // datapath now flushed with black idle pixels
        repeat (FLUSH_CYCLES - PIPE_DEPTH) begin
            check_value("r_out", 16'd0, r_out);
            check_value("g_out", 16'd0, g_out);
            check_value("b_out", 16'd0, b_out);
            idle_cycles(1);
        end
    endtask

    task automatic sweep_faces();
        send_relative(30000, 5000, -8000, 3'd2);
        send_relative(-30000, 5000, 8000, 3'd2);
        send_relative(4000, 30000, -9000, 3'd2);
        send_relative(4000, -30000, 9000, 3'd2);
        send_relative(-7000, 3000, 30000, 3'd2);
        send_relative(7000, -3000, -30000, 3'd2);
        // x and y equal in magnitude
        send_relative(20000, -20000, 1000, 3'd2);
        idle_cycles(PIPE_DEPTH);
    endtask

    task automatic mask_materials();
        send_relative(7000, -3000, -30000, 3'd0);
        send_relative(7000, -3000, -30000, 3'd1);
        send_relative(7000, -3000, -30000, 3'd2);
        send_relative(7000, -3000, -30000, 3'd5);
        idle_cycles(PIPE_DEPTH);
    endtask

    // -z face gets lights 0 and 1 at 0.8 each
    task automatic light_brightest_face();
        send_relative(-100, 200, -40000, 3'd2);
        idle_cycles(PIPE_DEPTH);
    endtask

    task automatic stream_back_to_back();
        repeat (STREAM_PIXELS) begin
            send_random_pixel();
        end
        idle_cycles(PIPE_DEPTH);
    endtask

    task automatic send_with_gaps();
        repeat (GAP_PIXELS) begin
            send_random_pixel();
            idle_cycles($urandom_range(MAX_GAP));
        end
        idle_cycles(PIPE_DEPTH);
    endtask

    //////////////////////////////
    // main sequence
    //////////////////////////////

    initial begin
        seed_word      = $urandom(32'hbf5b);
        pixels_checked = 0;
        rst_in         = 1'b1;
        valid_in       = 1'b0;
        ray_x          = '0;
        ray_y          = '0;
        ray_z          = '0;
        t_in           = '0;
        block_x        = '0;
        block_y        = '0;
        block_z        = '0;
        block_color    = material_e'(3'd7);
        for (int i = 0; i < PIPE_DEPTH; i++) begin
            exp_v[i] = 1'b0;
            exp_r[i] = 0;
            exp_g[i] = 0;
            exp_b[i] = 0;
        end
        verify_reset();
        sweep_faces();
        mask_materials();
        light_brightest_face();
        stream_back_to_back();
        send_with_gaps();
        $display("%0d pixels compared", pixels_checked);
        $display("NO ERRORS");
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: the tests did not finish within %0d ns", WATCHDOG_NS);
        $display("ERRORS FOUND");
        $fatal(1, "watchdog expired");
    end

endmodule

`default_nettype wire

// ==== list.f ====
rtl/shade_pkg.sv
rtl/shade_ifs.sv
rtl/hit_point_unit.sv
rtl/light_unit.sv
rtl/color_accumulator.sv
rtl/pixel_shader_top.sv
testbench/pixel_shader_tb.sv
